/* include/vram_settings.svh */
`ifndef VRAM_SETTINGS_SVH
`define VRAM_SETTINGS_SVH

// VRAM geometry
`define VRAM_ADDR_BITS 13
`define VRAM_DEPTH 8192

// CPU view of VRAM
`define VRAM_WINDOW_BASE 16'h8000
`define VRAM_WINDOW_TOP 16'h9FFF

// Open bus value seen by a locked-out CPU read
`define VRAM_BLOCKED_DATA 8'hFF

// Strobe to done, in clock cycles
`define VRAM_LATENCY 2

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the VRAM access unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_vram_subsystem \
	-f sim.f \
	-o sim_vram

status=0
./obj_dir/sim_vram > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
exit 0

/* sim.f */
+incdir+include
src/vram_pkg.sv
src/vram_request_capture.sv
src/vram_arbiter.sv
src/vram_ram.sv
src/vram_read_return.sv
src/vram_subsystem.sv
verification/vram_properties.sv
verification/tb_vram_subsystem.sv

/* src/vram_arbiter.sv */
`timescale 1ns/1ps

module vram_arbiter
	import vram_pkg::*;
(
	input logic clk,
	input logic reset,

	input vram_req_t cpu_req,
	input vram_req_t dma_req,
	input vram_req_t fetch_req,

	input logic render_lock,   // Pixel transfer owns VRAM
	input logic dma_vram_src,  // High while a VRAM sourced DMA runs

	output vram_access_t access
);

	logic cpu_lock;
	vram_access_t next;

	assign cpu_lock = render_lock || dma_vram_src;

	// Fetcher beats DMA beats CPU
	always_comb begin
		next.owner = master_none;
		next.write = 1'b0;
		next.addr = fetch_req.addr;
		next.wdata = cpu_req.wdata;
		next.blocked = 1'b0;

		if (fetch_req.valid) begin
			next.owner = master_fetch;
		end else if (dma_req.valid) begin
			next.owner = master_dma;
			next.addr = dma_req.addr;
		end else if (cpu_req.valid) begin
			next.owner = master_cpu;
			next.write = cpu_req.write;
			next.addr = cpu_req.addr;
			next.blocked = cpu_lock;  // Locked CPU keeps its slot but skips the array
		end

		// Losers still get their done, carried next to the winner
		next.cpu_lost = cpu_req.valid && (fetch_req.valid || dma_req.valid);
		next.dma_lost = dma_req.valid && fetch_req.valid;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			access.owner <= master_none;
			access.cpu_lost <= 1'b0;
			access.dma_lost <= 1'b0;
		end else begin
			access <= next;
		end
	end

endmodule

/* src/vram_pkg.sv */
`include "vram_settings.svh"

package vram_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [`VRAM_ADDR_BITS-1:0] vram_addr_t;
	typedef logic [7:0] vram_data_t;

	typedef enum logic [1:0] {
		master_none = 2'd0,
		master_cpu = 2'd1,
		master_dma = 2'd2,
		master_fetch = 2'd3
	} vram_master_e;

	// One captured request from a single master
	typedef struct packed {
		logic valid;
		logic write;
		vram_addr_t addr;
		vram_data_t wdata;
	} vram_req_t;

	// Access granted on the VRAM bus for one cycle
	typedef struct packed {
		vram_master_e owner;
		logic write;
		vram_addr_t addr;
		vram_data_t wdata;
		logic blocked;   // Owner does not touch the array
		logic cpu_lost;  // CPU lost arbitration, answer with open bus
		logic dma_lost;  // DMA lost to the fetcher, answer with open bus
	} vram_access_t;

	// Finished access of the bus owner
	typedef struct packed {
		vram_master_e owner;
		vram_data_t data;
		logic done;
	} vram_resp_t;

endpackage

/* src/vram_ram.sv */
`timescale 1ns/1ps
`include "vram_settings.svh"

module vram_ram
	import vram_pkg::*;
(
	input logic clk,
	input vram_access_t access,
	output vram_data_t rdata
);

	vram_data_t mem [`VRAM_DEPTH];
	logic do_write;

	assign do_write = (access.owner != master_none) && access.write && !access.blocked;

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[access.addr] <= access.wdata;
		end
		rdata <= mem[access.addr];  // Old data on a write cycle
	end

endmodule

/* src/vram_read_return.sv */
`timescale 1ns/1ps
`include "vram_settings.svh"

module vram_read_return
	import vram_pkg::*;
(
	input logic clk,
	input logic reset,

	input vram_access_t access,
	input vram_data_t rdata,

	output vram_data_t cpu_rdata,
	output logic cpu_done,

	output vram_data_t oam_wdata,
	output logic oam_we,

	output vram_data_t fetch_data,
	output logic fetch_done
);

	vram_access_t tag;  // Access that produced the current rdata
	vram_resp_t resp;

	always_ff @(posedge clk) begin
		if (reset) begin
			tag.owner <= master_none;
			tag.cpu_lost <= 1'b0;
			tag.dma_lost <= 1'b0;
		end else begin
			tag <= access;
		end
	end

	always_comb begin
		resp.owner = tag.owner;
		resp.done = (tag.owner != master_none);
		resp.data = tag.blocked ? `VRAM_BLOCKED_DATA : rdata;
	end

	// CPU answers on its own grant or when it lost arbitration
	assign cpu_done = (resp.done && (resp.owner == master_cpu)) || tag.cpu_lost;
	assign cpu_rdata = (resp.owner == master_cpu) ? resp.data : `VRAM_BLOCKED_DATA;

	assign oam_we = (resp.done && (resp.owner == master_dma)) || tag.dma_lost;
	assign oam_wdata = (resp.owner == master_dma) ? resp.data : `VRAM_BLOCKED_DATA;

	// Fetcher is never refused
	assign fetch_done = resp.done && (resp.owner == master_fetch);
	assign fetch_data = resp.data;

endmodule

/* src/vram_request_capture.sv */
`timescale 1ns/1ps
`include "vram_settings.svh"

module vram_request_capture
	import vram_pkg::*;
(
	input logic clk,
	input logic reset,

	input cpu_addr_t cpu_addr,
	input vram_data_t cpu_wdata,
	input logic cpu_rd,
	input logic cpu_wr,

	input logic dma_rd,
	input vram_addr_t dma_addr,

	input logic fetch_rd,
	input vram_addr_t fetch_addr,

	output vram_req_t cpu_req,
	output vram_req_t dma_req,
	output vram_req_t fetch_req
);

	logic in_window;
	cpu_addr_t cpu_offset;
	vram_req_t cpu_next;
	vram_req_t dma_next;
	vram_req_t fetch_next;

	// CPU only sees VRAM in the 0x8000..0x9FFF window
	assign in_window = (cpu_addr >= `VRAM_WINDOW_BASE) && (cpu_addr <= `VRAM_WINDOW_TOP);
	assign cpu_offset = cpu_addr - `VRAM_WINDOW_BASE;

	always_comb begin
		cpu_next.valid = (cpu_rd || cpu_wr) && in_window;
		cpu_next.write = cpu_wr;
		cpu_next.addr = cpu_offset[`VRAM_ADDR_BITS-1:0];
		cpu_next.wdata = cpu_wdata;
	end

	always_comb begin
		dma_next.valid = dma_rd;
		dma_next.write = 1'b0;  // DMA only reads VRAM
		dma_next.addr = dma_addr;
		dma_next.wdata = '0;
	end

	always_comb begin
		fetch_next.valid = fetch_rd;
		fetch_next.write = 1'b0;
		fetch_next.addr = fetch_addr;
		fetch_next.wdata = '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_req.valid <= 1'b0;
			dma_req.valid <= 1'b0;
			fetch_req.valid <= 1'b0;
		end else begin
			cpu_req <= cpu_next;
			dma_req <= dma_next;
			fetch_req <= fetch_next;
		end
	end

endmodule

/* src/vram_subsystem.sv */
`timescale 1ns/1ps

module vram_subsystem
	import vram_pkg::*;
(
	input logic clk,
	input logic reset,

	input cpu_addr_t cpu_addr,
	input vram_data_t cpu_wdata,
	input logic cpu_rd,
	input logic cpu_wr,

	input logic dma_rd,
	input vram_addr_t dma_addr,

	input logic fetch_rd,
	input vram_addr_t fetch_addr,

	input logic render_lock,
	input logic dma_vram_src,

	output vram_data_t cpu_rdata,
	output logic cpu_done,
	output vram_data_t oam_wdata,
	output logic oam_we,
	output vram_data_t fetch_data,
	output logic fetch_done
);

	vram_req_t cpu_req;
	vram_req_t dma_req;
	vram_req_t fetch_req;
	vram_access_t access;
	vram_data_t rdata;

	vram_request_capture u_capture (
		.clk(clk),
		.reset(reset),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_rd(cpu_rd),
		.cpu_wr(cpu_wr),
		.dma_rd(dma_rd),
		.dma_addr(dma_addr),
		.fetch_rd(fetch_rd),
		.fetch_addr(fetch_addr),
		.cpu_req(cpu_req),
		.dma_req(dma_req),
		.fetch_req(fetch_req)
	);

	vram_arbiter u_arbiter (
		.clk(clk),
		.reset(reset),
		.cpu_req(cpu_req),
		.dma_req(dma_req),
		.fetch_req(fetch_req),
		.render_lock(render_lock),
		.dma_vram_src(dma_vram_src),
		.access(access)
	);

	vram_ram u_ram (
		.clk(clk),
		.access(access),
		.rdata(rdata)
	);

	vram_read_return u_return (
		.clk(clk),
		.reset(reset),
		.access(access),
		.rdata(rdata),
		.cpu_rdata(cpu_rdata),
		.cpu_done(cpu_done),
		.oam_wdata(oam_wdata),
		.oam_we(oam_we),
		.fetch_data(fetch_data),
		.fetch_done(fetch_done)
	);

endmodule

/* include/vram_tb_settings.svh */
`ifndef VRAM_TB_SETTINGS_SVH
`define VRAM_TB_SETTINGS_SVH

// Testbench timing
`define TB_CLK_HALF 50
`define TB_DRIVE_DELAY 5
`define TB_RESET_CYCLES 5

// Run ends with a failure past this many cycles
`define TB_CYCLE_LIMIT 2000

// Number of distinct VRAM offsets the tests work on
`define TB_ADDR_COUNT 64

`endif

/* verification/tb_vram_subsystem.sv */
`timescale 1ns/1ps
`include "vram_settings.svh"
`include "vram_tb_settings.svh"

module tb_vram_subsystem
	import vram_pkg::*;
;

	logic clk;
	logic reset;
	cpu_addr_t cpu_addr;
	vram_data_t cpu_wdata;
	logic cpu_rd;
	logic cpu_wr;
	logic dma_rd;
	vram_addr_t dma_addr;
	logic fetch_rd;
	vram_addr_t fetch_addr;
	logic render_lock;
	logic dma_vram_src;
	vram_data_t cpu_rdata;
	logic cpu_done;
	vram_data_t oam_wdata;
	logic oam_we;
	vram_data_t fetch_data;
	logic fetch_done;

	int cycle = 0;
	vram_data_t shadow [`VRAM_DEPTH];
	vram_addr_t addr_list [`TB_ADDR_COUNT];

	// Expected outputs, indexed by the cycle in which they show up
	logic exp_cpu_done [`TB_CYCLE_LIMIT + 8];
	logic exp_cpu_chk [`TB_CYCLE_LIMIT + 8];
	vram_data_t exp_cpu_data [`TB_CYCLE_LIMIT + 8];
	logic exp_oam_we [`TB_CYCLE_LIMIT + 8];
	vram_data_t exp_oam_data [`TB_CYCLE_LIMIT + 8];
	logic exp_fetch_done [`TB_CYCLE_LIMIT + 8];
	vram_data_t exp_fetch_data [`TB_CYCLE_LIMIT + 8];

	vram_subsystem dut (.*);

	always #(`TB_CLK_HALF) clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= `TB_CYCLE_LIMIT) begin
			$display("run exceeded %0d cycles without finishing", `TB_CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	task report_mismatch(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		$display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
		$display("SIMULATION FAILED");
		$fatal(1, "mismatch");
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			assert (cpu_done === exp_cpu_done[cycle])
				else report_mismatch("cpu_done", 8'(exp_cpu_done[cycle]), 8'(cpu_done));
			assert (oam_we === exp_oam_we[cycle])
				else report_mismatch("oam_we", 8'(exp_oam_we[cycle]), 8'(oam_we));
			assert (fetch_done === exp_fetch_done[cycle])
				else report_mismatch("fetch_done", 8'(exp_fetch_done[cycle]), 8'(fetch_done));
			if (exp_cpu_chk[cycle]) begin
				assert (cpu_rdata === exp_cpu_data[cycle])
					else report_mismatch("cpu_rdata", exp_cpu_data[cycle], cpu_rdata);
			end
			if (exp_oam_we[cycle]) begin
				assert (oam_wdata === exp_oam_data[cycle])
					else report_mismatch("oam_wdata", exp_oam_data[cycle], oam_wdata);
			end
			if (exp_fetch_done[cycle]) begin
				assert (fetch_data === exp_fetch_data[cycle])
					else report_mismatch("fetch_data", exp_fetch_data[cycle], fetch_data);
			end
		end
	end

	// Expected response of the strobes driven in this cycle
	task predict;
		int k;
		logic blocked;
		vram_addr_t off;
		k = cycle + `VRAM_LATENCY + 1;  // Strobe is captured one edge after it is driven
		if (fetch_rd) begin
			exp_fetch_done[k] = 1'b1;
			exp_fetch_data[k] = shadow[fetch_addr];
		end
		if (dma_rd) begin
			exp_oam_we[k] = 1'b1;
			exp_oam_data[k] = fetch_rd ? `VRAM_BLOCKED_DATA : shadow[dma_addr];
		end
		if ((cpu_rd || cpu_wr) && cpu_addr >= `VRAM_WINDOW_BASE
				&& cpu_addr <= `VRAM_WINDOW_TOP) begin
			off = cpu_addr[`VRAM_ADDR_BITS-1:0];
			blocked = fetch_rd || dma_rd || render_lock || dma_vram_src;
			exp_cpu_done[k] = 1'b1;
			if (cpu_rd) begin
				exp_cpu_chk[k] = 1'b1;
				exp_cpu_data[k] = blocked ? `VRAM_BLOCKED_DATA : shadow[off];
			end else if (!blocked) begin
				shadow[off] = cpu_wdata;
			end
		end
	endtask

	task drive_cycle(input logic rd, input logic wr, input cpu_addr_t addr,
			input vram_data_t wdata, input logic drd, input vram_addr_t daddr,
			input logic frd, input vram_addr_t faddr);
		@(posedge clk);
		#(`TB_DRIVE_DELAY);
		cpu_rd = rd;
		cpu_wr = wr;
		cpu_addr = addr;
		cpu_wdata = wdata;
		dma_rd = drd;
		dma_addr = daddr;
		fetch_rd = frd;
		fetch_addr = faddr;
		predict();
	endtask

	task idle(input int n);
		repeat (n) drive_cycle(0, 0, '0, '0, 0, '0, 0, '0);
	endtask

	function automatic cpu_addr_t window(input vram_addr_t off);
		return `VRAM_WINDOW_BASE + off;
	endfunction

	function automatic vram_addr_t pick;
		return addr_list[$urandom_range(`TB_ADDR_COUNT - 1)];
	endfunction

	task write_then_read;
		for (int i = 0; i < `TB_ADDR_COUNT; i++)
			drive_cycle(0, 1, window(addr_list[i]), vram_data_t'($urandom), 0, '0, 0, '0);
		for (int i = 0; i < `TB_ADDR_COUNT; i++)
			drive_cycle(1, 0, window(addr_list[i]), '0, 0, '0, 0, '0);
		idle(4);
	endtask

	task locked_access;
		idle(3);  // Lock settles before any request reaches the arbiter
		for (int i = 0; i < 16; i++)
			drive_cycle(0, 1, window(addr_list[i]), vram_data_t'($urandom), 0, '0, 0, '0);
		for (int i = 0; i < 16; i++)
			drive_cycle(1, 0, window(addr_list[i]), '0, 0, '0, 0, '0);
		idle(4);
		render_lock = 1'b0;
		dma_vram_src = 1'b0;
		idle(3);
		for (int i = 0; i < 16; i++)
			drive_cycle(1, 0, window(addr_list[i]), '0, 0, '0, 0, '0);
		idle(4);
	endtask

	initial begin
		logic read_op;
		void'($urandom(47));
		clk = 1'b0;
		reset = 1'b1;
		render_lock = 1'b0;
		dma_vram_src = 1'b0;
		{cpu_rd, cpu_wr, dma_rd, fetch_rd} = '0;
		cpu_addr = '0;
		cpu_wdata = '0;
		dma_addr = '0;
		fetch_addr = '0;
		for (int i = 0; i < `TB_CYCLE_LIMIT + 8; i++) begin
			{exp_cpu_done[i], exp_cpu_chk[i], exp_oam_we[i], exp_fetch_done[i]} = '0;
			{exp_cpu_data[i], exp_oam_data[i], exp_fetch_data[i]} = '0;
		end
		for (int i = 0; i < `TB_ADDR_COUNT; i++)
			addr_list[i] = vram_addr_t'($urandom);

		repeat (`TB_RESET_CYCLES) @(posedge clk);
		#(`TB_DRIVE_DELAY);
		reset = 1'b0;
		idle(6);

		write_then_read();
		render_lock = 1'b1;
		locked_access();
		dma_vram_src = 1'b1;
		locked_access();

		// DMA alone, then DMA and CPU losing to the fetcher
		for (int i = 0; i < 32; i++)
			drive_cycle(0, 0, '0, '0, 1, pick(), 0, '0);
		for (int i = 0; i < 32; i++)
			drive_cycle(1, 0, window(pick()), '0, 1, pick(), 1, pick());
		idle(4);

		// Outside the window: nothing comes back, memory stays as it was
		for (int i = 0; i < 40; i++)
			drive_cycle(i[0], !i[0], (i < 20) ? cpu_addr_t'($urandom_range(16'h7FFF)) :
				cpu_addr_t'($urandom_range(16'hFFFF, 16'hA000)), vram_data_t'($urandom),
				0, '0, 0, '0);
		for (int i = 0; i < `TB_ADDR_COUNT; i++)
			drive_cycle(1, 0, window(addr_list[i]), '0, 0, '0, 0, '0);

		// CPU strobes either a read or a write, never both
		for (int i = 0; i < 400; i++) begin
			read_op = $urandom_range(1) == 1;
			drive_cycle(read_op, !read_op && $urandom_range(1) == 1, window(pick()),
				vram_data_t'($urandom), $urandom_range(3) == 0, pick(),
				$urandom_range(3) == 0, pick());
		end
		idle(6);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* verification/vram_properties.sv */
`timescale 1ns/1ps
`include "vram_settings.svh"

module vram_properties
	import vram_pkg::*;
(
	input logic clk,
	input logic reset,
	input cpu_addr_t cpu_addr,
	input logic cpu_rd,
	input logic cpu_wr,
	input logic dma_rd,
	input logic fetch_rd,
	input logic cpu_done,
	input logic oam_we,
	input logic fetch_done
);

	logic cpu_strobe;

	assign cpu_strobe = (cpu_rd || cpu_wr)
		&& (cpu_addr >= `VRAM_WINDOW_BASE) && (cpu_addr <= `VRAM_WINDOW_TOP);

	// All done strobes quiet right after a reset edge
	assert property (@(posedge clk) reset |=> (!cpu_done && !oam_we && !fetch_done))
		else $error("done strobe high after reset");

	// Captured at this edge, seen after two more edges
	assert property (@(posedge clk) disable iff (reset) fetch_rd |-> ##3 fetch_done)
		else $error("fetch_done missing after fetch_rd");

	assert property (@(posedge clk) disable iff (reset) dma_rd |-> ##3 oam_we)
		else $error("oam_we missing after dma_rd");

	assert property (@(posedge clk) disable iff (reset) cpu_strobe |-> ##3 cpu_done)
		else $error("cpu_done missing after an in window CPU strobe");

	// No done without a matching strobe
	assert property (@(posedge clk) disable iff (reset) cpu_done |-> $past(cpu_strobe, 3))
		else $error("cpu_done without an in window CPU strobe");

	assert property (@(posedge clk) disable iff (reset) fetch_done |-> $past(fetch_rd, 3))
		else $error("fetch_done without fetch_rd");

endmodule

bind vram_subsystem vram_properties u_props (.*);
